// ==== Makefile ====
VERILATOR := verilator
TOP := pipelineCoreTb
FILELIST := vlog.f
BUILD_FLAGS := --binary --assert --timing -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR := obj_dir
LOG := sim.log
FAIL_TEXT := Test failures found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire [isaPkg::RegIndexWidth-1:0] decodeRead1,
    input  wire [isaPkg::RegIndexWidth-1:0] decodeRead2,
    input  wire decodeNeed1,
    input  wire decodeNeed2,
    input  wire [isaPkg::WordWidth-1:0] decodeReg1,
    input  wire [isaPkg::WordWidth-1:0] decodeReg2,
    input  wire [isaPkg::RegIndexWidth-1:0] execRead1,
    input  wire [isaPkg::RegIndexWidth-1:0] execRead2,
    input  wire [isaPkg::WordWidth-1:0] execOrig1,
    input  wire [isaPkg::WordWidth-1:0] execOrig2,
    input  wire [isaPkg::RegIndexWidth-1:0] execDest,
    input  wire [isaPkg::RegIndexWidth-1:0] memDest,
    input  wire [isaPkg::RegIndexWidth-1:0] wbDest,
    input  wire execValid,
    input  wire memValid,
    input  wire execIsLoad,
    input  wire [isaPkg::WordWidth-1:0] execValue,
    input  wire [isaPkg::WordWidth-1:0] memValue,
    input  wire [isaPkg::WordWidth-1:0] wbValue,
    output logic [isaPkg::WordWidth-1:0] decodeOperand1,
    output logic [isaPkg::WordWidth-1:0] decodeOperand2,
    output logic [isaPkg::WordWidth-1:0] execOperand1,
    output logic [isaPkg::WordWidth-1:0] execOperand2,
    output logic loadUseStall
);

    // Youngest producer wins; register zero never forwards
    function automatic pipePkg::forwardSel pickSource(
        input logic [isaPkg::RegIndexWidth-1:0] index,
        input logic fromExec
    );
        pipePkg::forwardSel sel;
        sel = pipePkg::FwdRegFile;
        if (index != '0) begin
            if (fromExec && execValid && index == execDest)
                sel = pipePkg::FwdExec;
            else if (memValid && index == memDest)
                sel = pipePkg::FwdMem;
            else if (index == wbDest)
                sel = pipePkg::FwdWb;
        end
        return sel;
    endfunction

    function automatic logic [isaPkg::WordWidth-1:0] pickValue(
        input pipePkg::forwardSel sel,
        input logic [isaPkg::WordWidth-1:0] original
    );
        case (sel)
            pipePkg::FwdExec: return execValue;
            pipePkg::FwdMem: return memValue;
            pipePkg::FwdWb: return wbValue;
            default: return original;
        endcase
    endfunction

    always_comb begin
        decodeOperand1 = pickValue(pickSource(decodeRead1, 1'b1), decodeReg1);
        decodeOperand2 = pickValue(pickSource(decodeRead2, 1'b1), decodeReg2);
        // Execute never forwards from itself
        execOperand1 = pickValue(pickSource(execRead1, 1'b0), execOrig1);
        execOperand2 = pickValue(pickSource(execRead2, 1'b0), execOrig2);
    end

    assign loadUseStall = execIsLoad && (execDest != '0) &&
        ((decodeNeed1 && decodeRead1 == execDest) || (decodeNeed2 && decodeRead2 == execDest));

endmodule

`default_nettype wire

// ==== source/instructionDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder (
    input  wire [isaPkg::WordWidth-1:0] instruction,
    output pipePkg::decodedCtrl ctrl
);

    logic [isaPkg::OpcodeWidth-1:0] opcode;
    logic [isaPkg::FunctWidth-1:0] funct;
    logic [isaPkg::RegIndexWidth-1:0] rs;
    logic [isaPkg::RegIndexWidth-1:0] rt;
    logic [isaPkg::RegIndexWidth-1:0] rd;

    assign opcode = instruction[31:26];
    assign funct = instruction[5:0];
    assign rs = instruction[25:21];
    assign rt = instruction[20:16];
    assign rd = instruction[15:11];

    always_comb begin
        ctrl = '0;
        ctrl.read1 = rs;
        ctrl.read2 = rt;
        ctrl.imm = {{16{instruction[15]}}, instruction[15:0]};
        case (opcode)
            isaPkg::OpSpecial: begin
                ctrl.need1 = 1'b1;
                ctrl.need2 = 1'b1;
                ctrl.dest = rd;
                ctrl.writeSrc = pipePkg::WriteAlu;
                case (funct)
                    isaPkg::FunctAddu: ctrl.alu = pipePkg::AluAdd;
                    isaPkg::FunctSubu: ctrl.alu = pipePkg::AluSub;
                    isaPkg::FunctAnd: ctrl.alu = pipePkg::AluAnd;
                    isaPkg::FunctOr: ctrl.alu = pipePkg::AluOr;
                    isaPkg::FunctSlt: ctrl.alu = pipePkg::AluSlt;
                    isaPkg::FunctMult, isaPkg::FunctMultu: begin
                        ctrl.dest = '0;
                        ctrl.writeSrc = pipePkg::WriteNone;
                        ctrl.mulStart = 1'b1;
                        ctrl.mulSigned = (funct == isaPkg::FunctMult);
                    end
                    isaPkg::FunctMfhi, isaPkg::FunctMflo: begin
                        ctrl.need1 = 1'b0;
                        ctrl.need2 = 1'b0;
                        ctrl.writeSrc = pipePkg::WriteMultiplier;
                        ctrl.hiSelect = (funct == isaPkg::FunctMfhi);
                    end
                    default: ctrl = '0;
                endcase
            end
            isaPkg::OpOri: begin
                ctrl.need1 = 1'b1;
                ctrl.dest = rt;
                ctrl.alu = pipePkg::AluOr;
                ctrl.useImm = 1'b1;
                // ori takes a zero-extended immediate
                ctrl.imm = {16'b0, instruction[15:0]};
                ctrl.writeSrc = pipePkg::WriteAlu;
            end
            isaPkg::OpLui: begin
                ctrl.dest = rt;
                ctrl.alu = pipePkg::AluLui;
                ctrl.useImm = 1'b1;
                ctrl.writeSrc = pipePkg::WriteAlu;
            end
            isaPkg::OpAddiu: begin
                ctrl.need1 = 1'b1;
                ctrl.dest = rt;
                ctrl.useImm = 1'b1;
                ctrl.writeSrc = pipePkg::WriteAlu;
            end
            isaPkg::OpLw: begin
                ctrl.need1 = 1'b1;
                ctrl.dest = rt;
                ctrl.useImm = 1'b1;
                ctrl.writeSrc = pipePkg::WriteMemory;
                ctrl.memLoad = 1'b1;
            end
            isaPkg::OpSw: begin
                ctrl.need1 = 1'b1;
                ctrl.need2 = 1'b1;
                ctrl.useImm = 1'b1;
                ctrl.memStore = 1'b1;
            end
            isaPkg::OpBeq, isaPkg::OpBne: begin
                ctrl.need1 = 1'b1;
                ctrl.need2 = 1'b1;
                ctrl.branch = 1'b1;
                ctrl.branchNe = (opcode == isaPkg::OpBne);
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/isaPkg.sv ====
`default_nettype none

package isaPkg;

    localparam int WordWidth = 32;
    localparam int RegIndexWidth = 5;
    localparam int OpcodeWidth = 6;
    localparam int FunctWidth = 6;

    // Primary opcodes in bits 31:26
    localparam logic [OpcodeWidth-1:0] OpSpecial = 6'h00;
    localparam logic [OpcodeWidth-1:0] OpBeq = 6'h04;
    localparam logic [OpcodeWidth-1:0] OpBne = 6'h05;
    localparam logic [OpcodeWidth-1:0] OpAddiu = 6'h09;
    localparam logic [OpcodeWidth-1:0] OpOri = 6'h0d;
    localparam logic [OpcodeWidth-1:0] OpLui = 6'h0f;
    localparam logic [OpcodeWidth-1:0] OpLw = 6'h23;
    localparam logic [OpcodeWidth-1:0] OpSw = 6'h2b;

    // SPECIAL funct codes
    localparam logic [FunctWidth-1:0] FunctMfhi = 6'h10;
    localparam logic [FunctWidth-1:0] FunctMflo = 6'h12;
    localparam logic [FunctWidth-1:0] FunctMult = 6'h18;
    localparam logic [FunctWidth-1:0] FunctMultu = 6'h19;
    localparam logic [FunctWidth-1:0] FunctAddu = 6'h21;
    localparam logic [FunctWidth-1:0] FunctSubu = 6'h23;
    localparam logic [FunctWidth-1:0] FunctAnd = 6'h24;
    localparam logic [FunctWidth-1:0] FunctOr = 6'h25;
    localparam logic [FunctWidth-1:0] FunctSlt = 6'h2a;

endpackage

`default_nettype wire

// ==== source/multiplyUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module multiplyUnit (
    input  wire clk,
    input  wire reset,
    input  wire start,
    input  wire signedMode,
    input  wire [isaPkg::WordWidth-1:0] operandA,
    input  wire [isaPkg::WordWidth-1:0] operandB,
    output logic busy,
    output logic [isaPkg::WordWidth-1:0] hi,
    output logic [isaPkg::WordWidth-1:0] lo
);

    typedef enum logic {Idle, Busy} mulState;

    mulState state;
    pipePkg::mulCount count;
    logic [2*isaPkg::WordWidth-1:0] product;
    logic signed [2*isaPkg::WordWidth-1:0] signedProduct;
    logic [2*isaPkg::WordWidth-1:0] unsignedProduct;
    logic accept;
    logic finish;

    // Both products are formed at full width before the select
    assign signedProduct = $signed(operandA) * $signed(operandB);
    assign unsignedProduct = operandA * operandB;

    assign accept = start && (state == Idle);
    assign finish = (state == Busy) && (count == 1);
    assign busy = (state == Busy);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Idle;
            count <= '0;
        end else begin
            case (state)
                Idle: begin
                    if (start) begin
                        state <= Busy;
                        count <= pipePkg::mulCount'(pipePkg::MulLatency);
                    end
                end
                default: begin
                    count <= count - 1'b1;
                    if (finish) begin
                        state <= Idle;
                    end
                end
            endcase
        end
    end

    // Product held until the count runs out, then committed in one step
    always_ff @(posedge clk) begin
        if (accept) begin
            product <= signedMode ? signedProduct : unsignedProduct;
        end
        if (finish) begin
            {hi, lo} <= product;
        end
    end

endmodule

`default_nettype wire

// ==== source/pipePkg.sv ====
`default_nettype none

package pipePkg;

    localparam int MulLatency = 5;
    localparam int ProgDepth = 64;
    localparam int ProgAddrWidth = $clog2(ProgDepth);

    typedef logic [$clog2(MulLatency + 1)-1:0] mulCount;

    typedef enum logic [2:0] {AluAdd, AluSub, AluAnd, AluOr, AluSlt, AluLui} aluOp;

    // WriteNone must stay zero so an all-zero control word is a no-op
    typedef enum logic [1:0] {WriteNone, WriteAlu, WriteMemory, WriteMultiplier} writeSource;

    typedef enum logic [1:0] {FwdRegFile, FwdExec, FwdMem, FwdWb} forwardSel;

    typedef struct packed {
        logic [isaPkg::RegIndexWidth-1:0] read1;
        logic [isaPkg::RegIndexWidth-1:0] read2;
        logic [isaPkg::RegIndexWidth-1:0] dest;
        logic need1;
        logic need2;
        aluOp alu;
        logic useImm;
        logic [isaPkg::WordWidth-1:0] imm;
        writeSource writeSrc;
        logic memLoad;
        logic memStore;
        logic branch;
        logic branchNe;
        logic mulStart;
        logic mulSigned;
        logic hiSelect;
    } decodedCtrl;

endpackage

`default_nettype wire

// ==== source/pipelineCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineCore (
    input  wire clk,
    input  wire reset,
    input  wire progWriteEnable,
    input  wire [pipePkg::ProgAddrWidth-1:0] progAddress,
    input  wire [isaPkg::WordWidth-1:0] progData,
    output logic sbWriteEnable,
    output logic sbReadEnable,
    output logic [isaPkg::WordWidth-1:0] sbAddress,
    output logic [isaPkg::WordWidth-1:0] sbDataIn,
    input  wire [isaPkg::WordWidth-1:0] sbDataOut
);

    logic [isaPkg::WordWidth-1:0] pc;
    logic [isaPkg::WordWidth-1:0] fetchInstr;

    logic decodeBubble;
    logic [isaPkg::WordWidth-1:0] decodeInstr;
    logic [isaPkg::WordWidth-1:0] decodePc;
    logic [isaPkg::WordWidth-1:0] decodeWord;
    pipePkg::decodedCtrl decodeCtrl;
    logic [isaPkg::WordWidth-1:0] regData1;
    logic [isaPkg::WordWidth-1:0] regData2;
    logic [isaPkg::WordWidth-1:0] decodeOperand1;
    logic [isaPkg::WordWidth-1:0] decodeOperand2;
    logic branchTaken;
    logic [isaPkg::WordWidth-1:0] branchTarget;

    logic execBubble;
    pipePkg::decodedCtrl execCtrl;
    logic [isaPkg::WordWidth-1:0] execOrig1;
    logic [isaPkg::WordWidth-1:0] execOrig2;
    logic [isaPkg::WordWidth-1:0] execOperand1;
    logic [isaPkg::WordWidth-1:0] execOperand2;
    logic [isaPkg::WordWidth-1:0] aluB;
    logic [isaPkg::WordWidth-1:0] aluResult;
    logic [isaPkg::WordWidth-1:0] execResult;
    logic [isaPkg::RegIndexWidth-1:0] execDest;
    logic execValid;
    logic execIsLoad;

    logic mulStart;
    logic mulBusy;
    logic [isaPkg::WordWidth-1:0] mulHi;
    logic [isaPkg::WordWidth-1:0] mulLo;
    logic mulStall;
    logic loadUseStall;
    logic frontStall;

    logic memBubble;
    pipePkg::decodedCtrl memCtrl;
    logic [isaPkg::WordWidth-1:0] memResult;
    logic [isaPkg::WordWidth-1:0] memStoreData;
    logic [isaPkg::WordWidth-1:0] memValue;
    logic [isaPkg::RegIndexWidth-1:0] memDest;

    logic wbBubble;
    logic [isaPkg::RegIndexWidth-1:0] wbDestReg;
    logic [isaPkg::RegIndexWidth-1:0] wbDest;
    logic [isaPkg::WordWidth-1:0] wbValue;

    // Multiplier stall freezes fetch through execute, load-use only fetch and decode
    assign mulStall = !execBubble && mulBusy &&
        (execCtrl.mulStart || execCtrl.writeSrc == pipePkg::WriteMultiplier);
    assign frontStall = loadUseStall || mulStall;

    programMemory programMemory_i (
        .clk(clk),
        .writeEnable(progWriteEnable),
        .writeAddress(progAddress),
        .writeData(progData),
        .fetchAddress(pc[pipePkg::ProgAddrWidth+1:2]),
        .instruction(fetchInstr)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!frontStall) begin
            pc <= branchTaken ? branchTarget : pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decodeBubble <= 1'b1;
        end else if (!frontStall) begin
            decodeBubble <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!frontStall) begin
            decodeInstr <= fetchInstr;
            decodePc <= pc;
        end
    end

    // A bubble decodes as the all-zero word, which is a no-op
    assign decodeWord = decodeBubble ? '0 : decodeInstr;

    instructionDecoder instructionDecoder_i (
        .instruction(decodeWord),
        .ctrl(decodeCtrl)
    );

    registerFile registerFile_i (
        .clk(clk),
        .reset(reset),
        .readAddress1(decodeCtrl.read1),
        .readAddress2(decodeCtrl.read2),
        .readData1(regData1),
        .readData2(regData2),
        .writeAddress(wbDest),
        .writeData(wbValue)
    );

    // Branch resolves here, the delay slot is already in fetch
    assign branchTaken = decodeCtrl.branch &&
        ((decodeOperand1 == decodeOperand2) != decodeCtrl.branchNe);
    assign branchTarget = decodePc + 32'd4 + {decodeCtrl.imm[29:0], 2'b00};

    hazardUnit hazardUnit_i (
        .decodeRead1(decodeCtrl.read1),
        .decodeRead2(decodeCtrl.read2),
        .decodeNeed1(decodeCtrl.need1),
        .decodeNeed2(decodeCtrl.need2),
        .decodeReg1(regData1),
        .decodeReg2(regData2),
        .execRead1(execCtrl.read1),
        .execRead2(execCtrl.read2),
        .execOrig1(execOrig1),
        .execOrig2(execOrig2),
        .execDest(execDest),
        .memDest(memDest),
        .wbDest(wbDest),
        .execValid(execValid),
        .memValid(memCtrl.writeSrc != pipePkg::WriteNone),
        .execIsLoad(execIsLoad),
        .execValue(execResult),
        .memValue(memValue),
        .wbValue(wbValue),
        .decodeOperand1(decodeOperand1),
        .decodeOperand2(decodeOperand2),
        .execOperand1(execOperand1),
        .execOperand2(execOperand2),
        .loadUseStall(loadUseStall)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            execBubble <= 1'b1;
        end else if (!mulStall) begin
            execBubble <= decodeBubble || loadUseStall;
        end
    end

    // While held, operands keep tracking producers that retire underneath
    always_ff @(posedge clk) begin
        if (!mulStall) begin
            execCtrl <= decodeCtrl;
            execOrig1 <= decodeOperand1;
            execOrig2 <= decodeOperand2;
        end else begin
            execOrig1 <= execOperand1;
            execOrig2 <= execOperand2;
        end
    end

    assign aluB = execCtrl.useImm ? execCtrl.imm : execOperand2;

    always_comb begin
        case (execCtrl.alu)
            pipePkg::AluSub: aluResult = execOperand1 - aluB;
            pipePkg::AluAnd: aluResult = execOperand1 & aluB;
            pipePkg::AluOr: aluResult = execOperand1 | aluB;
            pipePkg::AluSlt: aluResult = {31'b0, $signed(execOperand1) < $signed(aluB)};
            pipePkg::AluLui: aluResult = {aluB[15:0], 16'b0};
            default: aluResult = execOperand1 + aluB;
        endcase
    end

    assign execResult = (execCtrl.writeSrc == pipePkg::WriteMultiplier) ?
        (execCtrl.hiSelect ? mulHi : mulLo) : aluResult;
    assign execDest = execBubble ? '0 : execCtrl.dest;
    assign execValid = (execCtrl.writeSrc == pipePkg::WriteAlu) ||
        (execCtrl.writeSrc == pipePkg::WriteMultiplier);
    assign execIsLoad = !execBubble && execCtrl.memLoad;
    assign mulStart = !execBubble && execCtrl.mulStart && !mulBusy;

    multiplyUnit multiplyUnit_i (
        .clk(clk),
        .reset(reset),
        .start(mulStart),
        .signedMode(execCtrl.mulSigned),
        .operandA(execOperand1),
        .operandB(execOperand2),
        .busy(mulBusy),
        .hi(mulHi),
        .lo(mulLo)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            memBubble <= 1'b1;
            wbBubble <= 1'b1;
        end else begin
            memBubble <= execBubble || mulStall;
            wbBubble <= memBubble;
        end
    end

    always_ff @(posedge clk) begin
        memCtrl <= execCtrl;
        memResult <= execResult;
        memStoreData <= execOperand2;
        wbDestReg <= memCtrl.dest;
        wbValue <= memValue;
    end

    // Load data is combinational from the bus, so it forwards like any result
    assign memValue = memCtrl.memLoad ? sbDataOut : memResult;
    assign memDest = memBubble ? '0 : memCtrl.dest;
    assign wbDest = wbBubble ? '0 : wbDestReg;

    assign sbWriteEnable = !memBubble && memCtrl.memStore;
    assign sbReadEnable = !memBubble && memCtrl.memLoad;
    assign sbAddress = memResult;
    assign sbDataIn = memStoreData;

endmodule

`default_nettype wire

// ==== source/programMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module programMemory (
    input  wire clk,
    input  wire writeEnable,
    input  wire [pipePkg::ProgAddrWidth-1:0] writeAddress,
    input  wire [isaPkg::WordWidth-1:0] writeData,
    input  wire [pipePkg::ProgAddrWidth-1:0] fetchAddress,
    output logic [isaPkg::WordWidth-1:0] instruction
);

    logic [isaPkg::WordWidth-1:0] words [pipePkg::ProgDepth];

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            words[writeAddress] <= writeData;
        end
    end

    assign instruction = words[fetchAddress];

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire clk,
    input  wire reset,
    input  wire [isaPkg::RegIndexWidth-1:0] readAddress1,
    input  wire [isaPkg::RegIndexWidth-1:0] readAddress2,
    output logic [isaPkg::WordWidth-1:0] readData1,
    output logic [isaPkg::WordWidth-1:0] readData2,
    input  wire [isaPkg::RegIndexWidth-1:0] writeAddress,
    input  wire [isaPkg::WordWidth-1:0] writeData
);

    // No storage behind register zero
    logic [isaPkg::WordWidth-1:0] regs [1:(1 << isaPkg::RegIndexWidth)-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < (1 << isaPkg::RegIndexWidth); i++) begin
                regs[i] <= '0;
            end
        end else if (writeAddress != '0) begin
            regs[writeAddress] <= writeData;
        end
    end

    assign readData1 = (readAddress1 == '0) ? '0 : regs[readAddress1];
    assign readData2 = (readAddress2 == '0) ? '0 : regs[readAddress2];

endmodule

`default_nettype wire

// ==== tb/pipelineCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineCoreTb;

    localparam int ClockPeriod = 8;
    localparam int DriveDelay = 1;
    localparam int ResetCycles = 8;
    localparam int TailCycles = 20;
    localparam int CyclesPerWord = 10;
    localparam int DataIndexWidth = 8;
    localparam string TestFile = "tb/pipeline_testdata.txt";

    logic clk;
    logic reset;
    logic progWriteEnable;
    logic [pipePkg::ProgAddrWidth-1:0] progAddress;
    logic [isaPkg::WordWidth-1:0] progData;
    logic sbWriteEnable;
    logic sbReadEnable;
    logic [isaPkg::WordWidth-1:0] sbAddress;
    logic [isaPkg::WordWidth-1:0] sbDataIn;
    logic [isaPkg::WordWidth-1:0] sbDataOut;

    logic [isaPkg::WordWidth-1:0] dataMem [1 << DataIndexWidth];

    // Parsed tests, flattened with per-test start and count
    string testNames [$];
    int progFirst [$];
    int progCount [$];
    logic [isaPkg::WordWidth-1:0] progWords [$];
    int storeFirst [$];
    int storeCount [$];
    logic [isaPkg::WordWidth-1:0] storeAddr [$];
    logic [isaPkg::WordWidth-1:0] storeData [$];

    int cycleCount;
    int cycleLimit;
    int storeBase;
    int storeTotal;
    int storeIndex;
    int testErrors;
    int passCount;
    int failCount;
    bit checking;

    pipelineCore pipelineCore_i (
        .clk(clk),
        .reset(reset),
        .progWriteEnable(progWriteEnable),
        .progAddress(progAddress),
        .progData(progData),
        .sbWriteEnable(sbWriteEnable),
        .sbReadEnable(sbReadEnable),
        .sbAddress(sbAddress),
        .sbDataIn(sbDataIn),
        .sbDataOut(sbDataOut)
    );

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    // Data memory, combinational read only while the read strobe is up
    assign sbDataOut = sbReadEnable ? dataMem[sbAddress[DataIndexWidth+1:2]] : '0;

    always @(posedge clk) begin
        if (sbWriteEnable) begin
            dataMem[sbAddress[DataIndexWidth+1:2]] <= sbDataIn;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, expected stores never arrived", cycleCount);
            $display("Test failures found");
            $finish;
        end
    end

    // Bus sampled mid-cycle
    always @(negedge clk) begin
        if (reset && (sbWriteEnable || sbReadEnable)) begin
            $display("Bus strobe high during reset at %0t", $time);
            testErrors++;
        end
        if (checking && sbWriteEnable) begin
            if (storeIndex >= storeTotal) begin
                $display("Extra store of %h to %h at %0t", sbDataIn, sbAddress, $time);
                testErrors++;
            end else if (sbAddress !== storeAddr[storeBase + storeIndex] ||
                    sbDataIn !== storeData[storeBase + storeIndex]) begin
                $display("FAIL %0t: store %0d wrote %h to %h, expected %h to %h",
                    $time, storeIndex, sbDataIn, sbAddress,
                    storeData[storeBase + storeIndex], storeAddr[storeBase + storeIndex]);
                testErrors++;
            end
            storeIndex++;
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic fillDataMemory();
        for (int i = 0; i < (1 << DataIndexWidth); i++) begin
            dataMem[i] <= $urandom;
        end
    endtask

    function automatic bit parseTestFile();
        int fd;
        int fields;
        string line;
        string kind;
        string name;
        logic [isaPkg::WordWidth-1:0] first;
        logic [isaPkg::WordWidth-1:0] second;
        bit ok;
        ok = 1'b1;
        fd = $fopen(TestFile, "r");
        if (fd == 0) begin
            return 1'b0;
        end
        while ($fgets(line, fd) > 0) begin
            kind = "";
            fields = $sscanf(line, "%s", kind);
            if (fields < 1 || kind.getc(0) == "#") begin
                continue;
            end
            if (kind == "test") begin
                fields = $sscanf(line, "%s %s", kind, name);
                testNames.push_back(name);
                progFirst.push_back(progWords.size());
                progCount.push_back(0);
                storeFirst.push_back(storeAddr.size());
                storeCount.push_back(0);
            end else if (kind == "prog" && testNames.size() > 0) begin
                fields = $sscanf(line, "%s %h", kind, first);
                progWords.push_back(first);
                progCount[progCount.size() - 1] += 1;
            end else if (kind == "store" && testNames.size() > 0) begin
                fields = $sscanf(line, "%s %h %h", kind, first, second);
                storeAddr.push_back(first);
                storeData.push_back(second);
                storeCount[storeCount.size() - 1] += 1;
            end else begin
                $display("Unreadable line in test file: %s", line);
                ok = 1'b0;
            end
        end
        $fclose(fd);
        return ok && testNames.size() > 0;
    endfunction

    task automatic runTest(input int index);
        int words;
        int first;
        words = progCount[index];
        first = progFirst[index];
        testErrors = 0;
        storeIndex = 0;
        storeBase = storeFirst[index];
        storeTotal = storeCount[index];
        reset = 1'b1;
        fillDataMemory();
        // Program goes in while the core is held
        for (int i = 0; i < words; i++) begin
            progWriteEnable = 1'b1;
            progAddress = pipePkg::ProgAddrWidth'(i);
            progData = progWords[first + i];
            nextCycle();
        end
        progWriteEnable = 1'b0;
        repeat (ResetCycles) nextCycle();
        checking = 1'b1;
        reset = 1'b0;
        while (storeIndex < storeTotal) begin
            nextCycle();
        end
        repeat (TailCycles) nextCycle();
        checking = 1'b0;
        if (testErrors == 0) begin
            passCount++;
            $display("%s: passed, %0d stores", testNames[index], storeTotal);
        end else begin
            failCount++;
            $display("%s: failed with %0d errors", testNames[index], testErrors);
        end
    endtask

    initial begin
        void'($urandom(39838));
        reset = 1'b1;
        progWriteEnable = 1'b0;
        progAddress = '0;
        progData = '0;
        checking = 1'b0;
        cycleCount = 0;
        cycleLimit = 0;
        storeBase = 0;
        storeTotal = 0;
        storeIndex = 0;
        testErrors = 0;
        passCount = 0;
        failCount = 0;
        if (!parseTestFile()) begin
            $display("Could not read the tests from %s", TestFile);
            failCount = 1;
        end else begin
            for (int t = 0; t < testNames.size(); t++) begin
                cycleLimit += ResetCycles + CyclesPerWord * progCount[t] + TailCycles;
            end
            nextCycle();
            for (int t = 0; t < testNames.size(); t++) begin
                runTest(t);
            end
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/pipelineCore_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineCoreSva (
    input wire clk,
    input wire reset,
    input wire sbWriteEnable,
    input wire sbReadEnable,
    input wire mulBusy
);

    int busyRun;

    // Busy cycles seen before the current one
    always_ff @(posedge clk) begin
        if (reset || !mulBusy) begin
            busyRun <= 0;
        end else begin
            busyRun <= busyRun + 1;
        end
    end

    busExclusive: assert property (@(posedge clk) !(sbWriteEnable && sbReadEnable))
        else $error("Bus read and write strobes high in the same cycle");

    quietInReset: assert property (@(posedge clk)
        reset && $past(reset) |-> !sbWriteEnable && !sbReadEnable)
        else $error("Bus strobe high while reset is asserted");

    busyBounded: assert property (@(posedge clk) disable iff (reset)
        !(mulBusy && busyRun >= pipePkg::MulLatency))
        else $error("Multiplier busy longer than its latency");

endmodule

bind pipelineCore pipelineCoreSva pipelineCoreSva_i (
    .clk(clk),
    .reset(reset),
    .sbWriteEnable(sbWriteEnable),
    .sbReadEnable(sbReadEnable),
    .mulBusy(mulBusy)
);

`default_nettype wire

// ==== tb/pipeline_testdata.txt ====
# Columns: test <name> | prog <instruction hex> | store <address hex> <data hex>
# Programs load from word 0; stores are listed in the order they must appear
test aluChain
prog 3c011234 # lui $1,0x1234
prog 34225678 # ori $2,$1,0x5678
prog 00411821 # addu $3,$2,$1
prog 00622023 # subu $4,$3,$2
prog 2485ffff # addiu $5,$4,-1
prog 00a23024 # and $6,$5,$2
prog 0083382a # slt $7,$4,$3
prog 00e64025 # or $8,$7,$6
prog ac080110 # sw $8,0x110
prog ac070114 # sw $7,0x114
prog ac020100 # sw $2,0x100
prog ac030104 # sw $3,0x104
prog ac040108 # sw $4,0x108
prog ac05010c # sw $5,0x10c
prog 1000ffff # beq $0,$0,-1
prog 00000000 # nop
store 00000110 12305679
store 00000114 00000001
store 00000100 12345678
store 00000104 24685678
store 00000108 12340000
store 0000010c 1233ffff
test loadUse
prog 3c01cafe # lui $1,0xcafe
prog 3421babe # ori $1,$1,0xbabe
prog ac010200 # sw $1,0x200
prog 8c020200 # lw $2,0x200
prog 24430011 # addiu $3,$2,0x11
prog ac030204 # sw $3,0x204
prog 8c040204 # lw $4,0x204
prog ac040208 # sw $4,0x208
prog 8c050200 # lw $5,0x200
prog 00000000 # nop
prog 00a43021 # addu $6,$5,$4
prog ac06020c # sw $6,0x20c
prog 1000ffff # beq $0,$0,-1
prog 00000000 # nop
store 00000200 cafebabe
store 00000204 cafebacf
store 00000208 cafebacf
store 0000020c 95fd758d
test branches
prog 34010005 # ori $1,$0,5
prog 34020005 # ori $2,$0,5
prog 10220002 # beq $1,$2,+2 taken
prog ac010300 # sw $1,0x300 delay slot
prog ac020304 # sw $2,0x304 skipped
prog 14220002 # bne $1,$2,+2 not taken
prog 34030007 # ori $3,$0,7 delay slot
prog ac030308 # sw $3,0x308
prog 14610002 # bne $3,$1,+2 taken
prog ac03030c # sw $3,0x30c delay slot
prog ac010310 # sw $1,0x310 skipped
prog 10610002 # beq $3,$1,+2 not taken
prog ac010314 # sw $1,0x314 delay slot
prog ac020318 # sw $2,0x318
prog 1000ffff # beq $0,$0,-1
prog 00000000 # nop
store 00000300 00000005
store 00000308 00000007
store 0000030c 00000007
store 00000314 00000005
store 00000318 00000005
test multiply
prog 3c01ffff # lui $1,0xffff
prog 3421fffd # ori $1,$1,0xfffd
prog 3c027fff # lui $2,0x7fff
prog 3442ffff # ori $2,$2,0xffff
prog 00220018 # mult $1,$2
prog 00001810 # mfhi $3
prog 00002012 # mflo $4
prog ac030040 # sw $3,0x40
prog ac040044 # sw $4,0x44
prog 00220019 # multu $1,$2
prog 00002812 # mflo $5
prog 00003010 # mfhi $6
prog ac050048 # sw $5,0x48
prog ac06004c # sw $6,0x4c
prog 00210018 # mult $1,$1
prog 00003810 # mfhi $7
prog 00004012 # mflo $8
prog ac070050 # sw $7,0x50
prog ac080054 # sw $8,0x54
prog 1000ffff # beq $0,$0,-1
prog 00000000 # nop
store 00000040 fffffffe
store 00000044 80000003
store 00000048 80000003
store 0000004c 7ffffffd
store 00000050 00000000
store 00000054 00000009
test storeOrder
prog 34010001 # ori $1,$0,1
prog ac010080 # sw $1,0x80
prog 24210001 # addiu $1,$1,1
prog ac010080 # sw $1,0x80
prog 24210001 # addiu $1,$1,1
prog ac010084 # sw $1,0x84
prog 8c020080 # lw $2,0x80
prog ac020088 # sw $2,0x88
prog 1000ffff # beq $0,$0,-1
prog 00000000 # nop
store 00000080 00000001
store 00000080 00000002
store 00000084 00000003
store 00000088 00000002

// ==== vlog.f ====
source/isaPkg.sv
source/pipePkg.sv
source/instructionDecoder.sv
source/registerFile.sv
source/multiplyUnit.sv
source/hazardUnit.sv
source/programMemory.sv
source/pipelineCore.sv
tb/pipelineCore_sva.sv
tb/pipelineCoreTb.sv
